// ==== isect_consts.svh ====
`ifndef ISECT_CONSTS_SVH
`define ISECT_CONSTS_SVH

// ==================================================
// Subsystem sizing
// ==================================================

// Bits per vertex / ray coordinate, signed
`define ISECT_COORD_W   16

// Triangle memory depth, entries
`define ISECT_NUM_TRI   64
`define ISECT_TRI_AW    6     // log2 of ISECT_NUM_TRI

// Peer cores sharing the one triangle memory
`define ISECT_NUM_CORES 2

// Thread id carried through with each ray job
`define ISECT_THREAD_W  5

`endif

// ==== isect_core.sv ====
`include "isect_consts.svh"

module isect_core import isect_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  ray_job_t                 job,
  output logic                     rd_req,
  output logic [`ISECT_TRI_AW-1:0] rd_addr,
  input  logic                     rd_gnt,
  input  logic                     rd_valid,
  input  tri_rec_t                 rd_data,
  output logic                     busy,
  output logic                     done,
  output isect_res_t               result
);

  localparam int AW    = `ISECT_TRI_AW;
  localparam int OUT_W = 4;   // Enough for grant-to-result depth
  localparam logic [AW-1:0] LAST_ADDR = AW'(`ISECT_NUM_TRI - 1);

  core_state_e        state_q, state_d;
  ray_job_t           job_q;           // Ray for the running job
  logic [AW-1:0]      next_addr_q;     // Next triangle to request
  logic [AW-1:0]      rd_id_q;         // Id of the read in flight to memory
  logic [OUT_W-1:0]   outstanding_q;   // Granted reads not yet out of math
  logic               closed_q;        // Terminator already seen
  logic               scan_end;
  logic               math_valid;
  math_out_t          math_out;
  logic signed [127:0] lhs, rhs;       // Cross-multiplied distances
  logic               better;

  // ==================================================
  // Scan state machine
  // ==================================================

  // Stop on an invalid record back or the last address granted
  assign scan_end = (rd_valid && !rd_data.valid) || (rd_gnt && rd_addr == LAST_ADDR);

  always_comb begin
    state_d = state_q;
    case (state_q)
      CORE_IDLE:  if (start) state_d = CORE_SCAN;
      CORE_SCAN:  if (scan_end) state_d = CORE_DRAIN;
      CORE_DRAIN: if (outstanding_q == '0) state_d = CORE_DONE;
      CORE_DONE:  state_d = CORE_IDLE;
      default:    state_d = CORE_IDLE;
    endcase
  end

  assign busy    = (state_q != CORE_IDLE);
  assign done    = (state_q == CORE_DONE);
  assign rd_req  = (state_q == CORE_SCAN);   // Held through denied grants
  assign rd_addr = next_addr_q;

  // Job and read id are payload
  always_ff @(posedge clk) begin
    if (state_q == CORE_IDLE && start) begin
      job_q <= job;
    end
    if (rd_gnt) begin
      rd_id_q <= rd_addr;   // Data comes back next cycle
    end
  end

  // ==================================================
  // Math pipeline
  // ==================================================

  isect_math u_math (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rd_valid),
    .in_tri    (rd_data),
    .in_id     (rd_id_q),
    .in_last   (!rd_data.valid || rd_id_q == LAST_ADDR),
    .orig      (job_q.orig),
    .dir       (job_q.dir),
    .out_valid (math_valid),
    .out       (math_out)
  );

  // Nearest rule, strict less keeps the earlier id on a tie
  assign lhs    = $signed(math_out.t_num) * $signed(result.det);
  assign rhs    = $signed(result.t_num) * $signed(math_out.det);
  assign better = !result.hit || (lhs < rhs);

  // ==================================================
  // Control and result registers
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= CORE_IDLE;
      next_addr_q   <= '0;
      outstanding_q <= '0;
      closed_q      <= 1'b0;
      result        <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == CORE_IDLE && start) begin
        next_addr_q   <= job.start_id;
        outstanding_q <= '0;
        closed_q      <= 1'b0;
        result        <= '{thread_id: job.thread_id, default: '0};
      end else begin
        if (rd_gnt) begin
          next_addr_q <= next_addr_q + 1'b1;  // Advance in the grant cycle
        end
        outstanding_q <= outstanding_q + OUT_W'(rd_gnt) - OUT_W'(math_valid);
        if (math_valid && math_out.last) begin
          closed_q <= 1'b1;                   // Later results are dropped
        end
        if (math_valid && !closed_q && math_out.hit && better) begin
          result.hit    <= 1'b1;
          result.tri_id <= math_out.tri_id;
          result.t_num  <= math_out.t_num;
          result.det    <= math_out.det;
        end
      end
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> !busy
  ) else $error("isect_core start while busy");

  // Every math result must match a grant still counted
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) math_valid |-> (outstanding_q != '0)
  ) else $error("isect_core outstanding count underflow");

endmodule

// ==== isect_math.sv ====
`include "isect_consts.svh"

module isect_math import isect_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  tri_rec_t                 in_tri,
  input  logic [`ISECT_TRI_AW-1:0] in_id,
  input  logic                     in_last,
  input  vec3_t                    orig,
  input  vec3_t                    dir,     // Ray held stable for the job
  output logic                     out_valid,
  output math_out_t                out
);

  // Component k of a vector, sign extended to wide_t
  function automatic wide_t comp(input vec3_t v, input int k);
    case (k)
      0:       return wide_t'($signed(v.x));
      1:       return wide_t'($signed(v.y));
      default: return wide_t'($signed(v.z));
    endcase
  endfunction

  function automatic wide_t dot3(input wide_t a [3], input wide_t b [3]);
    return a[0] * b[0] + a[1] * b[1] + a[2] * b[2];
  endfunction

  // Stage 1 registers
  logic                     s1_valid;
  logic [`ISECT_TRI_AW-1:0] s1_id;
  logic                     s1_last, s1_tvalid;
  wide_t                    e1_s1 [3];
  wide_t                    e2_s1 [3];
  wide_t                    s_s1  [3];
  // Stage 2 registers
  logic                     s2_valid;
  logic [`ISECT_TRI_AW-1:0] s2_id;
  logic                     s2_last, s2_tvalid;
  wide_t                    p_s2  [3];
  wide_t                    q_s2  [3];
  wide_t                    e2_s2 [3];
  wide_t                    s_s2  [3];
  wide_t                    det_s2;
  // Combinational terms
  wide_t                    d_w [3];
  wide_t                    p_c [3];
  wide_t                    q_c [3];
  wide_t                    det_c, u_c, v_c, t_c;
  logic                     hit_c;

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      d_w[k] = comp(dir, k);
    end
  end

  // ==================================================
  // Stage 1 : edges and origin offset
  // ==================================================

  always_ff @(posedge clk) begin
    for (int k = 0; k < 3; k++) begin
      e1_s1[k] <= comp(in_tri.v1, k) - comp(in_tri.v0, k);
      e2_s1[k] <= comp(in_tri.v2, k) - comp(in_tri.v0, k);
      s_s1[k]  <= comp(orig, k) - comp(in_tri.v0, k);
    end
    s1_id     <= in_id;
    s1_last   <= in_last;
    s1_tvalid <= in_tri.valid;   // Invalid slot can never hit
  end

  // ==================================================
  // Stage 2 : p = dir x e2, q = s x e1, det = e1 . p
  // ==================================================

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      p_c[k] = d_w[(k+1)%3] * e2_s1[(k+2)%3] - d_w[(k+2)%3] * e2_s1[(k+1)%3];
      q_c[k] = s_s1[(k+1)%3] * e1_s1[(k+2)%3] - s_s1[(k+2)%3] * e1_s1[(k+1)%3];
    end
  end

  assign det_c = dot3(e1_s1, p_c);

  always_ff @(posedge clk) begin
    p_s2      <= p_c;
    q_s2      <= q_c;
    e2_s2     <= e2_s1;    // Still needed for t
    s_s2      <= s_s1;     // Still needed for u
    det_s2    <= det_c;
    s2_id     <= s1_id;
    s2_last   <= s1_last;
    s2_tvalid <= s1_tvalid;
  end

  // ==================================================
  // Stage 3 : barycentrics, distance and hit rule
  // ==================================================

  assign u_c = dot3(s_s2, p_s2);
  assign v_c = dot3(d_w, q_s2);
  assign t_c = dot3(e2_s2, q_s2);

  // Front face only, inside the triangle, in front of the origin
  assign hit_c = s2_tvalid && (det_s2 > 0) && (u_c >= 0) && (v_c >= 0) &&
                 ((u_c + v_c) <= det_s2) && (t_c > 0);

  always_ff @(posedge clk) begin
    out.tri_id <= s2_id;
    out.last   <= s2_last;
    out.hit    <= hit_c;
    out.t_num  <= t_c;
    out.det    <= det_s2;
  end

  // Valid strobe walks with the data, 3 cycles end to end
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

endmodule

// ==== isect_pkg.sv ====
`include "isect_consts.svh"

package isect_pkg;

  // ==================================================
  // Geometry types
  // ==================================================

  typedef logic signed [`ISECT_COORD_W-1:0] coord_t;  // One signed coordinate

  // Wide signed value for every product and dot result
  typedef logic signed [63:0] wide_t;

  // Packed 3-vector, x in the top bits
  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // One triangle slot in memory, valid clear marks end of list
  typedef struct packed {
    logic  valid;
    vec3_t v0;
    vec3_t v1;
    vec3_t v2;
  } tri_rec_t;

  // ==================================================
  // Job and result types
  // ==================================================

  typedef struct packed {
    logic [`ISECT_THREAD_W-1:0] thread_id;
    logic [`ISECT_TRI_AW-1:0]   start_id;   // First triangle to test
    vec3_t                      orig;
    vec3_t                      dir;
  } ray_job_t;

  // Nearest hit as the fraction t_num / det
  typedef struct packed {
    logic [`ISECT_THREAD_W-1:0] thread_id;
    logic                       hit;
    logic [`ISECT_TRI_AW-1:0]   tri_id;
    wide_t                      t_num;
    wide_t                      det;
  } isect_res_t;

  // One finished test out of the math pipeline
  typedef struct packed {
    logic [`ISECT_TRI_AW-1:0] tri_id;
    logic                     last;     // Record ended the list
    logic                     hit;
    wide_t                    t_num;
    wide_t                    det;
  } math_out_t;

  typedef enum logic [1:0] {
    CORE_IDLE,   // Waiting for start
    CORE_SCAN,   // Requesting reads
    CORE_DRAIN,  // Reads stopped, pipeline emptying
    CORE_DONE    // One-cycle done pulse
  } core_state_e;

endpackage

// ==== isect_tb.sv ====
`include "isect_consts.svh"

module isect_tb import isect_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NC       = `ISECT_NUM_CORES;
  localparam int NT       = `ISECT_NUM_TRI;
  localparam int TAW      = `ISECT_TRI_AW;
  localparam int TW       = `ISECT_THREAD_W;
  localparam int NUM_JOBS = 17;                          // Jobs started over the whole run
  localparam int WD_CYCLES = NUM_JOBS * (NT + 20) * 2 + 200;

  logic                        clk;
  logic                        rst_n;
  logic                        load_en;
  logic [TAW-1:0]              load_addr;
  tri_rec_t                    load_tri;
  logic [NC-1:0]               start;
  ray_job_t                    job;
  logic [NC-1:0]               busy;
  logic [NC-1:0]               done;
  isect_res_t [NC-1:0]         result;

  tri_rec_t img [NT];   // Copy of what the DUT memory holds
  int       errors;

  isect_top u_dut (.*);

  always #5 clk = ~clk;  // 10 ns period

  // ==================================================
  // Stimulus helpers
  // ==================================================

  // Signed value in [-span, span]
  function automatic coord_t rnd_coord(input int span);
    return coord_t'(int'($urandom % (2 * span + 1)) - span);
  endfunction

  function automatic vec3_t rnd_vec(input int span);
    vec3_t v;
    v.x = rnd_coord(span);
    v.y = rnd_coord(span);
    v.z = rnd_coord(span);
    return v;
  endfunction

  function automatic tri_rec_t rnd_tri();
    tri_rec_t t;
    t.valid = 1'b1;
    t.v0    = rnd_vec(120);
    t.v1    = rnd_vec(120);
    t.v2    = rnd_vec(120);
    return t;
  endfunction

  // Ray with a positive z step so planted triangles face it
  function automatic ray_job_t rnd_ray(input int start_id);
    ray_job_t j;
    j.thread_id = TW'($urandom);
    j.start_id  = TAW'(start_id);
    j.orig      = rnd_vec(100);
    j.dir.x     = rnd_coord(3);
    j.dir.y     = rnd_coord(3);
    j.dir.z     = coord_t'(1 + $urandom % 4);
    return j;
  endfunction

  // Right triangle in the plane z = P.z with P = orig + k*dir one unit inside
  // Front facing for dz > 0 and t_num / det works out to k
  function automatic tri_rec_t pierce_tri(input ray_job_t j, input int k, input int a);
    tri_rec_t t;
    int       px, py, pz;
    px = int'(j.orig.x) + k * int'(j.dir.x) - 1;
    py = int'(j.orig.y) + k * int'(j.dir.y) - 1;
    pz = int'(j.orig.z) + k * int'(j.dir.z);
    t.valid = 1'b1;
    t.v0 = '{x: coord_t'(px), y: coord_t'(py), z: coord_t'(pz)};
    t.v1 = '{x: coord_t'(px), y: coord_t'(py + a), z: coord_t'(pz)};
    t.v2 = '{x: coord_t'(px + a), y: coord_t'(py), z: coord_t'(pz)};
    return t;
  endfunction

  // Whole image random and valid with an optional terminator slot
  task automatic fill_random(input int term_at);
    for (int i = 0; i < NT; i++) begin
      img[i] = rnd_tri();
    end
    if (term_at >= 0) begin
      img[term_at].valid = 1'b0;
    end
  endtask

  // One record per cycle through the load port while the cores are idle
  task automatic load_image();
    for (int i = 0; i < NT; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= TAW'(i);
      load_tri  <= img[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // ==================================================
  // Reference model
  // ==================================================

  function automatic void to_arr(input vec3_t v, output longint a [3]);
    a[0] = longint'(v.x);
    a[1] = longint'(v.y);
    a[2] = longint'(v.z);
  endfunction

  function automatic longint dot_prod(input longint a [3], input longint b [3]);
    return a[0] * b[0] + a[1] * b[1] + a[2] * b[2];
  endfunction

  function automatic void cross_prod(input longint a [3], input longint b [3],
                                     output longint c [3]);
    c[0] = a[1] * b[2] - a[2] * b[1];
    c[1] = a[2] * b[0] - a[0] * b[2];
    c[2] = a[0] * b[1] - a[1] * b[0];
  endfunction

  // Nearest front-facing hit from start_id up to the terminator or the end
  function automatic isect_res_t model_job(input ray_job_t j);
    isect_res_t r;
    longint     o [3], d [3], a0 [3], a1 [3], a2 [3];
    longint     e1 [3], e2 [3], s [3], p [3], q [3];
    longint     det, u, v, t;
    r           = '0;
    r.thread_id = j.thread_id;
    to_arr(j.orig, o);
    to_arr(j.dir, d);
    for (int id = int'(j.start_id); id < NT; id++) begin
      if (!img[id].valid) break;            // Nothing past the terminator counts
      to_arr(img[id].v0, a0);
      to_arr(img[id].v1, a1);
      to_arr(img[id].v2, a2);
      for (int k = 0; k < 3; k++) begin
        e1[k] = a1[k] - a0[k];
        e2[k] = a2[k] - a0[k];
        s[k]  = o[k] - a0[k];
      end
      cross_prod(d, e2, p);
      cross_prod(s, e1, q);
      det = dot_prod(e1, p);
      u   = dot_prod(s, p);
      v   = dot_prod(d, q);
      t   = dot_prod(e2, q);
      // Strict compare keeps the lower id on equal t/det
      if (det > 0 && u >= 0 && v >= 0 && u + v <= det && t > 0 &&
          (!r.hit || t * r.det < r.t_num * det)) begin
        r.hit    = 1'b1;
        r.tri_id = TAW'(id);
        r.t_num  = t;
        r.det    = det;
      end
    end
    return r;
  endfunction

  // ==================================================
  // Checking
  // ==================================================

  task automatic check_field(input int core, input string name,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      errors++;
      $display("MISMATCH core%0d %s expected %h actual %h", core, name, exp, act);
    end
  endtask

  task automatic check_result(input int core, input isect_res_t exp, input isect_res_t act);
    check_field(core, "thread_id", 64'(exp.thread_id), 64'(act.thread_id));
    check_field(core, "hit", 64'(exp.hit), 64'(act.hit));
    check_field(core, "tri_id", 64'(exp.tri_id), 64'(act.tri_id));
    check_field(core, "t_num", exp.t_num, act.t_num);
    check_field(core, "det", exp.det, act.det);
  endtask

  // Start the cores in mask on back-to-back cycles and check each done pulse
  task automatic run_jobs(input logic [NC-1:0] mask, input ray_job_t j0, input ray_job_t j1);
    isect_res_t    exp [NC];
    logic [NC-1:0] seen;
    int            cycles;
    exp[0] = model_job(j0);
    exp[1] = model_job(j1);
    seen   = '0;
    cycles = 0;
    assert (busy == '0) else begin
      errors++;
      $display("MISMATCH busy expected 0 actual %h", busy);
    end
    for (int c = 0; c < NC; c++) begin
      if (mask[c]) begin
        @(posedge clk);
        start <= NC'(1 << c);               // Shared job bus so one core per cycle
        job   <= (c == 0) ? j0 : j1;
      end
    end
    @(posedge clk);
    start <= '0;
    while (seen != mask && cycles < NT * 4 + 40) begin
      @(negedge clk);                       // Outputs settled mid cycle
      cycles++;
      for (int c = 0; c < NC; c++) begin
        // A started core stays busy up to and through its done cycle
        assert (busy[c] == (mask[c] && !seen[c])) else begin
          errors++;
          $display("MISMATCH core%0d busy expected %h actual %h", c,
                   mask[c] && !seen[c], busy[c]);
        end
        if (mask[c] && done[c]) begin
          seen[c] = 1'b1;
          check_result(c, exp[c], result[c]);
        end else if (done[c]) begin
          errors++;
          $display("MISMATCH core%0d done expected 0 actual %h", c, done[c]);
        end
      end
    end
    assert (seen == mask) else begin
      errors++;
      $display("No done pulse within %0d cycles of start", cycles);
    end
    @(negedge clk);                         // Cores back in idle
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    ray_job_t ja, jb;
    tri_rec_t tr;
    int       s0, s1;
    void'($urandom(32'hcee9));
    errors    = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_tri  = '0;
    start     = '0;
    job       = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet outputs after reset
    repeat (4) begin
      @(negedge clk);
      assert (busy == '0 && done == '0) else begin
        errors++;
        $display("MISMATCH busy expected 0 actual %h, done expected 0 actual %h", busy, done);
      end
    end

    // Single core on random lists with a planted hit
    for (int n = 0; n < 4; n++) begin
      s0 = $urandom % 16;
      ja = rnd_ray(s0);
      fill_random(s0 + 8 + $urandom % 12);
      img[s0 + 2 + $urandom % 5] = pierce_tri(ja, 1 + $urandom % 10, 4 + $urandom % 12);
      load_image();
      run_jobs(2'b01, ja, ja);
    end

    // Both cores contend for the memory
    for (int n = 0; n < 4; n++) begin
      s0 = $urandom % 12;
      s1 = $urandom % 12;
      ja = rnd_ray(s0);
      jb = rnd_ray(s1);
      fill_random(20 + $urandom % 10);
      img[s0 + 3] = pierce_tri(ja, 1 + $urandom % 10, 4 + $urandom % 12);
      img[s1 + 5] = pierce_tri(jb, 1 + $urandom % 10, 4 + $urandom % 12);
      load_image();
      run_jobs(2'b11, ja, jb);
    end

    // Terminator hides a closer hit
    ja = rnd_ray(4);
    fill_random(-1);
    img[5]       = pierce_tri(ja, 8, 6);
    img[7].valid = 1'b0;
    img[9]       = pierce_tri(ja, 2, 6);
    load_image();
    run_jobs(2'b01, ja, ja);

    // Reversed z step sees every triangle from behind so nothing hits
    for (int i = 0; i < NT; i++) begin
      img[i] = pierce_tri(ja, 1 + i % 10, 5);
    end
    jb          = ja;
    jb.start_id = '0;
    jb.dir.z    = -ja.dir.z;
    load_image();
    run_jobs(2'b10, jb, jb);

    // Closer back face is skipped and the tie goes to the lower id
    ja = rnd_ray(0);
    fill_random(12);
    tr     = pierce_tri(ja, 2, 8);
    img[1] = '{valid: 1'b1, v0: tr.v0, v1: tr.v2, v2: tr.v1};
    img[3] = pierce_tri(ja, 5, 9);          // Same t/det as id 6 with a larger det
    img[6] = pierce_tri(ja, 5, 5);
    load_image();
    run_jobs(2'b10, ja, ja);

    // Without a terminator the scan stops at the last address
    ja = rnd_ray(NT - 4);
    jb = rnd_ray(NT - 1);
    fill_random(-1);
    img[NT - 2] = pierce_tri(ja, 3, 7);
    img[NT - 1] = pierce_tri(jb, 4, 7);
    load_image();
    run_jobs(2'b11, ja, jb);

    $display("Run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the job count
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Timeout, tests still running after %0d cycles, %0d errors", WD_CYCLES, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== isect_top.sv ====
`include "isect_consts.svh"

module isect_top import isect_pkg::*; (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     load_en,
  input  logic [`ISECT_TRI_AW-1:0]                 load_addr,
  input  tri_rec_t                                 load_tri,
  input  logic [`ISECT_NUM_CORES-1:0]              start,
  input  ray_job_t                                 job,
  output logic [`ISECT_NUM_CORES-1:0]              busy,
  output logic [`ISECT_NUM_CORES-1:0]              done,
  output isect_res_t [`ISECT_NUM_CORES-1:0]        result
);

  // Core side of the arbiter
  logic [`ISECT_NUM_CORES-1:0]                     rd_req, rd_gnt, rd_valid;
  logic [`ISECT_NUM_CORES-1:0][`ISECT_TRI_AW-1:0]  rd_addr;
  // Memory side
  logic                                            mem_rd_en;
  logic [`ISECT_TRI_AW-1:0]                        mem_rd_addr;
  tri_rec_t                                        mem_rd_data;  // Broadcast to both cores

  isect_core u_core0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start[0]),
    .job      (job),
    .rd_req   (rd_req[0]),
    .rd_addr  (rd_addr[0]),
    .rd_gnt   (rd_gnt[0]),
    .rd_valid (rd_valid[0]),
    .rd_data  (mem_rd_data),
    .busy     (busy[0]),
    .done     (done[0]),
    .result   (result[0])
  );

  isect_core u_core1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start[1]),
    .job      (job),
    .rd_req   (rd_req[1]),
    .rd_addr  (rd_addr[1]),
    .rd_gnt   (rd_gnt[1]),
    .rd_valid (rd_valid[1]),
    .rd_data  (mem_rd_data),
    .busy     (busy[1]),
    .done     (done[1]),
    .result   (result[1])
  );

  mem_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_gnt      (rd_gnt),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .rd_valid    (rd_valid)
  );

  tri_mem u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_tri  (load_tri),
    .rd_en     (mem_rd_en),
    .rd_addr   (mem_rd_addr),
    .rd_data   (mem_rd_data)
  );

endmodule

// ==== mem_arbiter.sv ====
`include "isect_consts.svh"

module mem_arbiter (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic [`ISECT_NUM_CORES-1:0]                     rd_req,
  input  logic [`ISECT_NUM_CORES-1:0][`ISECT_TRI_AW-1:0]  rd_addr,
  output logic [`ISECT_NUM_CORES-1:0]                     rd_gnt,
  output logic                                            mem_rd_en,
  output logic [`ISECT_TRI_AW-1:0]                        mem_rd_addr,
  output logic [`ISECT_NUM_CORES-1:0]                     rd_valid
);

  localparam int N     = `ISECT_NUM_CORES;
  localparam int SEL_W = (N > 1) ? $clog2(N) : 1;

  logic [SEL_W-1:0] last_q;   // Last winner, search starts past it
  logic [SEL_W-1:0] sel;      // This cycle's winner
  logic [SEL_W-1:0] owner_q;  // Who gets the data next cycle
  logic             valid_q;  // Read was issued last cycle
  logic             found;

  // ==================================================
  // Round-robin pick
  // ==================================================

  always_comb begin
    rd_gnt = '0;
    sel    = last_q;
    found  = 1'b0;
    // Walk from last winner + 1 round to last winner itself
    for (int i = 1; i <= N; i++) begin
      if (!found && rd_req[(int'(last_q) + i) % N]) begin
        found                           = 1'b1;
        rd_gnt[(int'(last_q) + i) % N]  = 1'b1;
        sel                             = SEL_W'((int'(last_q) + i) % N);
      end
    end
  end

  assign mem_rd_en   = found;          // One read per cycle at most
  assign mem_rd_addr = rd_addr[sel];   // Winner's address to memory

  // ==================================================
  // Owner tag for the returning record
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q  <= '0;
      owner_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= found;
      if (found) begin
        last_q  <= sel;                // Rotate priority past winner
        owner_q <= sel;
      end
    end
  end

  // Data strobe goes to the tagged owner only
  always_comb begin
    rd_valid = '0;
    if (valid_q) begin
      rd_valid[owner_q] = 1'b1;
    end
  end

  a_gnt_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(rd_gnt)
  ) else $error("mem_arbiter granted more than one core");

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run isect_tb with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module isect_tb -f tb.f -o isect_sim \
  > build.log 2>&1 \
  && ./obj_dir/isect_sim > sim.log 2>&1 \
  || echo "Build or run error, see build.log and sim.log"
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb.f ====
+incdir+.
isect_pkg.sv
tri_mem.sv
mem_arbiter.sv
isect_math.sv
isect_core.sv
isect_top.sv
isect_tb.sv

// ==== tri_mem.sv ====
`include "isect_consts.svh"

module tri_mem import isect_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_en,
  input  logic [`ISECT_TRI_AW-1:0] load_addr,
  input  tri_rec_t                 load_tri,
  input  logic                     rd_en,
  input  logic [`ISECT_TRI_AW-1:0] rd_addr,
  output tri_rec_t                 rd_data
);

  // ==================================================
  // Storage
  // ==================================================

  tri_rec_t mem_q [`ISECT_NUM_TRI];  // One record per triangle id

  // Single port, load side writes and the arbiter reads
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem_q[load_addr] <= load_tri;    // Host fill, cores idle
    end
    if (rd_en) begin
      rd_data <= mem_q[rd_addr];       // Out one cycle after rd_en
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  // Host must not load while any core still scans
  a_no_load_on_read: assert property (
    @(posedge clk) disable iff (!rst_n) !(load_en && rd_en)
  ) else $error("tri_mem load and read in the same cycle");

endmodule
